//--- include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// word and address widths
`define WORD_MAG_W  30
`define ADDR_W      12
`define OP_W        6
`define DIGIT_W     5
`define MEM_DEPTH   4096

// any op code not listed here halts
`define OP_STOP     6'd0
`define OP_ADD      6'd1
`define OP_SUB      6'd2
`define OP_AND      6'd3
`define OP_OUTPUT   6'd4

// sign digit codes for the output device
`define DIGIT_PLUS  5'd16
`define DIGIT_MINUS 5'd17
`define OUT_DIGITS  10

`endif

//--- hw/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    typedef struct packed {
        logic                   sign;
        logic [`WORD_MAG_W-1:0] mag;
    } word_t;

    // overlays the magnitude of a word
    typedef struct packed {
        logic [`OP_W-1:0]   op;
        logic [`ADDR_W-1:0] addr1;
        logic [`ADDR_W-1:0] addr2;
    } instr_t;

    typedef struct packed {
        logic is_add;
        logic is_sub;
        logic is_and;
        logic is_output;
        logic is_stop;
    } order_t;

    typedef struct packed {
        logic       clear_c;
        logic       mem_to_c;
        logic       pnl_to_c;   // panel may set c
        logic       c_to_a;
        logic       c_to_b;
        logic       operate;
        logic       shift_c3;
        logic       out_to_c;   // c back from a after output
        logic [1:0] alu_op;     // low bits of the op code
    } au_cmd_t;

    typedef struct packed {
        logic strt_to_sel;
        logic addr1_to_sel;
        logic addr2_to_sel;
        logic inc_strt;
    } addr_cmd_t;

endpackage

//--- hw/arith_unit.sv
`include "core_consts.svh"

module arith_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::au_cmd_t cmd,
    input  core_pkg::word_t   read_data,
    input  logic              pnl_do_arr_c,
    input  core_pkg::word_t   pnl_arr_reg_c_value,
    output core_pkg::word_t   reg_c,
    output logic [2:0]        out_digit
);
    import core_pkg::*;

    word_t reg_a;
    word_t reg_b;
    word_t b_eff;    // b with the sign flipped for sub
    word_t result;

    always_comb begin
        b_eff = reg_b;
        if (cmd.alu_op == 2'(`OP_SUB)) begin
            b_eff.sign = ~reg_b.sign;
        end

        result = '0;
        if (cmd.alu_op == 2'(`OP_AND)) begin
            result.sign = reg_a.sign & reg_b.sign;
            result.mag  = reg_a.mag & reg_b.mag;
        end else begin
            if (reg_a.sign == b_eff.sign) begin
                result.sign = reg_a.sign;
                result.mag  = reg_a.mag + b_eff.mag;    // wraps mod 2**30
            end else if (reg_a.mag >= b_eff.mag) begin
                result.sign = reg_a.sign;
                result.mag  = reg_a.mag - b_eff.mag;
            end else begin
                result.sign = b_eff.sign;
                result.mag  = b_eff.mag - reg_a.mag;
            end
            // no negative zero
            if (result.mag == '0) begin
                result.sign = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_a <= '0;
            reg_b <= '0;
            reg_c <= '0;
        end else begin
            if (cmd.c_to_a) begin
                reg_a <= reg_c;
            end
            if (cmd.c_to_b) begin
                reg_b <= reg_c;
            end

            if (cmd.clear_c) begin
                reg_c <= '0;
            end else if (cmd.mem_to_c) begin
                reg_c <= read_data;
            end else if (cmd.pnl_to_c && pnl_do_arr_c) begin
                reg_c <= pnl_arr_reg_c_value;
            end else if (cmd.operate) begin
                reg_c <= result;
            end else if (cmd.shift_c3) begin
                reg_c.mag <= {reg_c.mag[`WORD_MAG_W-4:0], 3'b000};   // sign stays
            end else if (cmd.out_to_c) begin
                reg_c <= reg_a;
            end
        end
    end

    assign out_digit = reg_c.mag[`WORD_MAG_W-1 -: 3];    // top octal digit

endmodule

//--- hw/operator.sv
`include "core_consts.svh"

module operator (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_code,
    input  core_pkg::instr_t instr,
    output core_pkg::order_t order,
    output logic [`OP_W-1:0] op_code
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_code <= '0;
        end else if (load_code) begin
            op_code <= instr.op;
        end
    end

    // one flag per order
    always_comb begin
        order = '0;
        case (op_code)
            `OP_ADD:    order.is_add    = 1'b1;
            `OP_SUB:    order.is_sub    = 1'b1;
            `OP_AND:    order.is_and    = 1'b1;
            `OP_OUTPUT: order.is_output = 1'b1;
            `OP_STOP:   order.is_stop   = 1'b1;
            default:    order.is_stop   = 1'b1;    // undefined codes halt too
        endcase
    end

endmodule

//--- hw/pulse_unit.sv
`include "core_consts.svh"

module pulse_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pnl_start,
    input  logic                pnl_do_write,
    input  logic                pnl_do_read,
    input  core_pkg::order_t    order,
    input  logic                mem_reply,
    input  logic                io_done,
    input  logic                io_shift,
    output core_pkg::au_cmd_t   au_cmd,
    output core_pkg::addr_cmd_t addr_cmd,
    output logic                mem_read,
    output logic                mem_write,
    output logic                load_code,
    output logic                io_start,
    output logic                running
);

    typedef enum logic [4:0] {
        S_IDLE, S_RD_WAIT,
        S_FETCH, S_FETCH_RD, S_FETCH_WAIT, S_DECODE, S_CHECK,
        S_A_WAIT, S_TO_A, S_B_RD, S_B_WAIT, S_TO_B, S_OPERATE, S_WRITE,
        S_OUT, S_OUT_WAIT, S_OUT_END
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        au_cmd    = '0;
        addr_cmd  = '0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        load_code = 1'b0;
        io_start  = 1'b0;
        au_cmd.alu_op = order.is_and ? 2'(`OP_AND) :
                        order.is_sub ? 2'(`OP_SUB) : 2'(`OP_ADD);
        case (state)
            S_IDLE: begin
                au_cmd.pnl_to_c = 1'b1;
                if (pnl_start) begin
                    state_nxt = S_FETCH;
                end else if (pnl_do_write) begin
                    mem_write = 1'b1;    // c to select address
                end else if (pnl_do_read) begin
                    mem_read  = 1'b1;
                    state_nxt = S_RD_WAIT;
                end
            end
            S_RD_WAIT: begin
                au_cmd.mem_to_c = mem_reply;
                if (mem_reply) begin
                    state_nxt = S_IDLE;
                end
            end
            S_FETCH: begin
                addr_cmd.strt_to_sel = 1'b1;
                state_nxt = S_FETCH_RD;
            end
            S_FETCH_RD: begin
                mem_read  = 1'b1;
                state_nxt = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
                au_cmd.mem_to_c = mem_reply;
                if (mem_reply) begin
                    state_nxt = S_DECODE;
                end
            end
            S_DECODE: begin
                load_code = 1'b1;
                addr_cmd.inc_strt     = 1'b1;
                addr_cmd.addr1_to_sel = 1'b1;
                state_nxt = S_CHECK;
            end
            S_CHECK: begin
                if (order.is_stop) begin
                    au_cmd.clear_c = 1'b1;
                    state_nxt = S_IDLE;
                end else begin
                    // c still holds the instruction while address one is read
                    mem_read = 1'b1;
                    addr_cmd.addr2_to_sel = 1'b1;
                    state_nxt = S_A_WAIT;
                end
            end
            S_A_WAIT: begin
                au_cmd.mem_to_c = mem_reply;
                if (mem_reply) begin
                    state_nxt = S_TO_A;
                end
            end
            S_TO_A: begin
                au_cmd.c_to_a = 1'b1;
                state_nxt = order.is_output ? S_OUT : S_B_RD;
            end
            S_B_RD: begin
                mem_read  = 1'b1;
                state_nxt = S_B_WAIT;
            end
            S_B_WAIT: begin
                au_cmd.mem_to_c = mem_reply;
                if (mem_reply) begin
                    state_nxt = S_TO_B;
                end
            end
            S_TO_B: begin
                au_cmd.c_to_b = 1'b1;
                state_nxt = S_OPERATE;
            end
            S_OPERATE: begin
                au_cmd.operate = 1'b1;
                state_nxt = S_WRITE;
            end
            S_WRITE: begin
                mem_write = 1'b1;    // result to address two
                state_nxt = S_FETCH;
            end
            S_OUT: begin
                io_start  = 1'b1;
                state_nxt = S_OUT_WAIT;
            end
            S_OUT_WAIT: begin
                au_cmd.shift_c3 = io_shift;
                if (io_done) begin
                    state_nxt = S_OUT_END;
                end
            end
            S_OUT_END: begin
                au_cmd.out_to_c = 1'b1;
                state_nxt = S_FETCH;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            running <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == S_IDLE && pnl_start) begin
                running <= 1'b1;
            end else if (state == S_CHECK && order.is_stop) begin
                running <= 1'b0;
            end
        end
    end

endmodule

//--- hw/addr_regs.sv
`include "core_consts.svh"

module addr_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::addr_cmd_t cmd,
    input  core_pkg::instr_t    instr,
    input  logic                pnl_do_arr_strt,
    input  logic [`ADDR_W-1:0]  pnl_arr_strt_value,
    input  logic                pnl_do_arr_sel,
    input  logic [`ADDR_W-1:0]  pnl_arr_sel_value,
    output logic [`ADDR_W-1:0]  strt_value,
    output logic [`ADDR_W-1:0]  sel_value
);

    // instruction counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strt_value <= '0;
        end else if (pnl_do_arr_strt) begin
            strt_value <= pnl_arr_strt_value;
        end else if (cmd.inc_strt) begin
            strt_value <= strt_value + 1'b1;    // wraps at the top of memory
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_value <= '0;
        end else if (pnl_do_arr_sel) begin
            sel_value <= pnl_arr_sel_value;
        end else if (cmd.strt_to_sel) begin
            sel_value <= strt_value;
        end else if (cmd.addr1_to_sel) begin
            sel_value <= instr.addr1;
        end else if (cmd.addr2_to_sel) begin
            sel_value <= instr.addr2;
        end
    end

endmodule

//--- hw/memory.sv
`include "core_consts.svh"

module memory (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic [`ADDR_W-1:0] addr,
    input  core_pkg::word_t    write_data,
    output core_pkg::word_t    read_data,
    output logic               mem_reply
);

    logic [`WORD_MAG_W:0] mem [`MEM_DEPTH];    // sign and magnitude

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[addr] <= write_data;
        end
        if (mem_read) begin
            read_data <= mem[addr];    // held until the next read
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_reply <= 1'b0;
        end else begin
            mem_reply <= mem_read;
        end
    end

endmodule

//--- hw/io_unit.sv
`include "core_consts.svh"

module io_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                sign,
    input  logic [2:0]          digit,
    output logic                shift_c,
    output logic                done,
    output logic                dev_output_rdy,
    input  logic                dev_output_ack,
    output logic [`DIGIT_W-1:0] dev_output_data
);

    typedef enum logic [1:0] {IO_IDLE, IO_SEND, IO_GAP, IO_LOAD} io_state_t;

    io_state_t  state;
    logic [3:0] cnt;    // octal digits presented so far

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= IO_IDLE;
            cnt             <= '0;
            dev_output_rdy  <= 1'b0;
            dev_output_data <= '0;
        end else begin
            case (state)
                IO_IDLE: begin
                    if (start) begin
                        cnt             <= '0;
                        dev_output_data <= sign ? `DIGIT_MINUS : `DIGIT_PLUS;
                        dev_output_rdy  <= 1'b1;
                        state           <= IO_SEND;
                    end
                end
                IO_SEND: begin
                    if (dev_output_ack) begin
                        dev_output_rdy <= 1'b0;
                        state          <= IO_GAP;
                    end
                end
                IO_GAP: begin
                    state <= (cnt == 4'(`OUT_DIGITS)) ? IO_IDLE : IO_LOAD;
                end
                IO_LOAD: begin
                    // next digit is on top of the shifted c
                    dev_output_data <= {{(`DIGIT_W-3){1'b0}}, digit};
                    dev_output_rdy  <= 1'b1;
                    cnt             <= cnt + 4'd1;
                    state           <= IO_SEND;
                end
            endcase
        end
    end

    assign shift_c = (state == IO_GAP) && (cnt != '0);    // not after the sign
    assign done    = (state == IO_GAP) && (cnt == 4'(`OUT_DIGITS));

endmodule

//--- hw/core_top.sv
`include "core_consts.svh"

module core_top (
    input  logic                clk,
    input  logic                rst_n,

    output logic                dev_output_rdy,       // handshake
    input  logic                dev_output_ack,       // handshake
    output logic [`DIGIT_W-1:0] dev_output_data,

    input  logic                pnl_do_arr_c,         // pulse
    input  core_pkg::word_t     pnl_arr_reg_c_value,
    input  logic                pnl_do_arr_strt,      // pulse
    input  logic [`ADDR_W-1:0]  pnl_arr_strt_value,
    input  logic                pnl_do_arr_sel,       // pulse
    input  logic [`ADDR_W-1:0]  pnl_arr_sel_value,
    input  logic                pnl_do_write,         // pulse
    input  logic                pnl_do_read,          // pulse
    input  logic                pnl_start,            // pulse
    output logic                pnl_running,

    output logic [`OP_W-1:0]    pnl_op_code,
    output logic [`ADDR_W-1:0]  pnl_strt_value,
    output logic [`ADDR_W-1:0]  pnl_sel_value,
    output core_pkg::word_t     pnl_reg_c_value
);
    import core_pkg::*;

    word_t      read_data;
    instr_t     c_instr;
    order_t     order;
    au_cmd_t    au_cmd;
    addr_cmd_t  addr_cmd;
    logic       mem_read;
    logic       mem_write;
    logic       mem_reply;
    logic       load_code;
    logic       io_start;
    logic       io_done;
    logic       io_shift;
    logic [2:0] out_digit;

    assign c_instr = pnl_reg_c_value.mag;    // instruction fields sit in c

    arith_unit u_arith_unit (
        .clk                 (clk),
        .rst_n               (rst_n),
        .cmd                 (au_cmd),
        .read_data           (read_data),
        .pnl_do_arr_c        (pnl_do_arr_c),
        .pnl_arr_reg_c_value (pnl_arr_reg_c_value),
        .reg_c               (pnl_reg_c_value),
        .out_digit           (out_digit)
    );

    operator u_operator (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_code (load_code),
        .instr     (c_instr),
        .order     (order),
        .op_code   (pnl_op_code)
    );

    pulse_unit u_pulse_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .pnl_start    (pnl_start),
        .pnl_do_write (pnl_do_write),
        .pnl_do_read  (pnl_do_read),
        .order        (order),
        .mem_reply    (mem_reply),
        .io_done      (io_done),
        .io_shift     (io_shift),
        .au_cmd       (au_cmd),
        .addr_cmd     (addr_cmd),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .load_code    (load_code),
        .io_start     (io_start),
        .running      (pnl_running)
    );

    addr_regs u_addr_regs (
        .clk                (clk),
        .rst_n              (rst_n),
        .cmd                (addr_cmd),
        .instr              (c_instr),
        .pnl_do_arr_strt    (pnl_do_arr_strt),
        .pnl_arr_strt_value (pnl_arr_strt_value),
        .pnl_do_arr_sel     (pnl_do_arr_sel),
        .pnl_arr_sel_value  (pnl_arr_sel_value),
        .strt_value         (pnl_strt_value),
        .sel_value          (pnl_sel_value)
    );

    memory u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .addr       (pnl_sel_value),
        .write_data (pnl_reg_c_value),
        .read_data  (read_data),
        .mem_reply  (mem_reply)
    );

    io_unit u_io_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (io_start),
        .sign            (pnl_reg_c_value.sign),
        .digit           (out_digit),
        .shift_c         (io_shift),
        .done            (io_done),
        .dev_output_rdy  (dev_output_rdy),
        .dev_output_ack  (dev_output_ack),
        .dev_output_data (dev_output_data)
    );

endmodule

//--- dv/core_sva.sv
`include "core_consts.svh"

module core_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                dev_output_rdy,
    input logic                dev_output_ack,
    input logic [`DIGIT_W-1:0] dev_output_data,
    input logic                pnl_do_arr_c,
    input logic                pnl_do_arr_strt,
    input logic                pnl_do_arr_sel,
    input logic                pnl_do_write,
    input logic                pnl_do_read,
    input logic                pnl_start,
    input logic                pnl_running
);

    logic pnl_pulse;    // any panel pulse

    assign pnl_pulse = pnl_do_arr_c | pnl_do_arr_strt | pnl_do_arr_sel
                     | pnl_do_write | pnl_do_read | pnl_start;

    // digit held until the device takes it
    rdy_held: assert property (@(posedge clk) disable iff (!rst_n)
        dev_output_rdy && !dev_output_ack |=> dev_output_rdy && $stable(dev_output_data))
        else $error("rdy or data changed before ack");

    pnl_idle_only: assert property (@(posedge clk) disable iff (!rst_n)
        pnl_pulse |-> !pnl_running)
        else $error("panel pulse while the machine runs");

    reset_idle: assert property (@(posedge clk) !rst_n |=> !pnl_running)
        else $error("running level high after reset");

endmodule

//--- dv/core_tb.sv
`include "core_consts.svh"

module core_tb;
    import core_pkg::*;

    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [`WORD_MAG_W-1:0] mag_t;

    localparam int DATA_BASE   = 'h100;
    localparam int DATA_N      = 8;
    localparam int PROG_BASE   = 'h800;
    localparam int RUN_TIMEOUT = 5000;

    localparam int MODE_ADDSUB = 0;
    localparam int MODE_AND    = 1;
    localparam int MODE_OUTPUT = 2;
    localparam int MODE_MIXED  = 3;
    localparam int MODE_UNDEF  = 4;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                dev_output_rdy;
    logic                dev_output_ack = 1'b0;
    logic [`DIGIT_W-1:0] dev_output_data;
    logic                pnl_do_arr_c;
    word_t               pnl_arr_reg_c_value;
    logic                pnl_do_arr_strt;
    addr_t               pnl_arr_strt_value;
    logic                pnl_do_arr_sel;
    addr_t               pnl_arr_sel_value;
    logic                pnl_do_write;
    logic                pnl_do_read;
    logic                pnl_start;
    logic                pnl_running;
    logic [`OP_W-1:0]    pnl_op_code;
    addr_t               pnl_strt_value;
    addr_t               pnl_sel_value;
    word_t               pnl_reg_c_value;

    word_t               model_mem [`MEM_DEPTH];
    logic [4:0]          exp_digits [$];
    logic [4:0]          seen_digits [$];
    int                  ack_delay = 0;

    core_top core_top_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dev_output_rdy      (dev_output_rdy),
        .dev_output_ack      (dev_output_ack),
        .dev_output_data     (dev_output_data),
        .pnl_do_arr_c        (pnl_do_arr_c),
        .pnl_arr_reg_c_value (pnl_arr_reg_c_value),
        .pnl_do_arr_strt     (pnl_do_arr_strt),
        .pnl_arr_strt_value  (pnl_arr_strt_value),
        .pnl_do_arr_sel      (pnl_do_arr_sel),
        .pnl_arr_sel_value   (pnl_arr_sel_value),
        .pnl_do_write        (pnl_do_write),
        .pnl_do_read         (pnl_do_read),
        .pnl_start           (pnl_start),
        .pnl_running         (pnl_running),
        .pnl_op_code         (pnl_op_code),
        .pnl_strt_value      (pnl_strt_value),
        .pnl_sel_value       (pnl_sel_value),
        .pnl_reg_c_value     (pnl_reg_c_value)
    );

    bind core_top core_sva core_sva_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .dev_output_rdy  (dev_output_rdy),
        .dev_output_ack  (dev_output_ack),
        .dev_output_data (dev_output_data),
        .pnl_do_arr_c    (pnl_do_arr_c),
        .pnl_do_arr_strt (pnl_do_arr_strt),
        .pnl_do_arr_sel  (pnl_do_arr_sel),
        .pnl_do_write    (pnl_do_write),
        .pnl_do_read     (pnl_do_read),
        .pnl_start       (pnl_start),
        .pnl_running     (pnl_running)
    );

    always #2 clk = ~clk;

    // output device acks each digit after a random delay
    always @(posedge clk) begin
        if (!rst_n) begin
            dev_output_ack <= 1'b0;
            ack_delay      <= 0;
        end else if (dev_output_ack) begin
            dev_output_ack <= 1'b0;
        end else if (dev_output_rdy) begin
            if (ack_delay == 0) begin
                dev_output_ack <= 1'b1;
                seen_digits.push_back(dev_output_data);
                ack_delay <= $urandom_range(4, 0);
            end else begin
                ack_delay <= ack_delay - 1;
            end
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic abort_run(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    // sign-magnitude result of one order
    function automatic word_t model_alu(input logic [5:0] op, input word_t a, input word_t b);
        word_t       r;
        logic        b_sign;
        logic [30:0] total;
        r      = '0;
        b_sign = (op == `OP_SUB) ? ~b.sign : b.sign;
        if (op == `OP_AND) begin
            r.sign = a.sign & b.sign;
            r.mag  = a.mag & b.mag;
        end else if (a.sign == b_sign) begin
            total  = {1'b0, a.mag} + {1'b0, b.mag};
            r.sign = a.sign;
            r.mag  = total[29:0];    // wraps mod 2**30
        end else if (a.mag > b.mag) begin
            r.sign = a.sign;
            r.mag  = a.mag - b.mag;
        end else begin
            r.sign = b_sign;
            r.mag  = b.mag - a.mag;
        end
        if (op != `OP_AND && r.mag == '0) begin
            r.sign = 1'b0;    // zero is positive
        end
        return r;
    endfunction

    function automatic void push_word_digits(input word_t w);
        int k;
        exp_digits.push_back(w.sign ? `DIGIT_MINUS : `DIGIT_PLUS);
        for (k = `OUT_DIGITS - 1; k >= 0; k--) begin
            exp_digits.push_back({2'b00, w.mag[3*k +: 3]});
        end
    endfunction

    function automatic void model_run(input addr_t start_addr);
        addr_t  pc;
        instr_t ins;
        logic   halted;
        int     steps;
        pc     = start_addr;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 64) begin
            ins   = model_mem[pc].mag;
            pc    = pc + addr_t'(1);
            steps = steps + 1;
            case (ins.op)
                `OP_ADD, `OP_SUB, `OP_AND: begin
                    model_mem[ins.addr2] = model_alu(ins.op, model_mem[ins.addr1],
                                                     model_mem[ins.addr2]);
                end
                `OP_OUTPUT: push_word_digits(model_mem[ins.addr1]);
                default:    halted = 1'b1;    // stop and undefined codes
            endcase
        end
    endfunction

    function automatic word_t random_word();
        word_t w;
        w.sign = 1'($urandom);
        case ($urandom_range(3, 0))
            0:       w.mag = '0;
            1:       w.mag = mag_t'($urandom_range(7, 0));
            default: w.mag = mag_t'($urandom);
        endcase
        return w;
    endfunction

    task automatic set_sel(input addr_t addr);
        @(posedge clk);
        pnl_arr_sel_value <= addr;
        pnl_do_arr_sel    <= 1'b1;
        @(posedge clk);
        pnl_do_arr_sel    <= 1'b0;
        @(negedge clk);
        compare_value("pnl_sel_value", 64'(pnl_sel_value), 64'(addr));
    endtask

    task automatic set_strt(input addr_t addr);
        @(posedge clk);
        pnl_arr_strt_value <= addr;
        pnl_do_arr_strt    <= 1'b1;
        @(posedge clk);
        pnl_do_arr_strt    <= 1'b0;
        @(negedge clk);
        compare_value("pnl_strt_value", 64'(pnl_strt_value), 64'(addr));
    endtask

    task automatic set_c(input word_t w);
        @(posedge clk);
        pnl_arr_reg_c_value <= w;
        pnl_do_arr_c        <= 1'b1;
        @(posedge clk);
        pnl_do_arr_c        <= 1'b0;
        @(negedge clk);
        compare_value("pnl_reg_c_value", 64'(pnl_reg_c_value), 64'(w));
    endtask

    task automatic deposit(input addr_t addr, input word_t w);
        set_sel(addr);
        set_c(w);
        @(posedge clk);
        pnl_do_write <= 1'b1;
        @(posedge clk);
        pnl_do_write <= 1'b0;
        model_mem[addr] = w;
    endtask

    // word shows on c two cycles after the read pulse
    task automatic read_word(input addr_t addr);
        set_sel(addr);
        @(posedge clk);
        pnl_do_read <= 1'b1;
        @(posedge clk);
        pnl_do_read <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare_value("pnl_reg_c_value", 64'(pnl_reg_c_value), 64'(model_mem[addr]));
    endtask

    task automatic start_run();
        int cycles;
        @(posedge clk);
        pnl_start <= 1'b1;
        @(posedge clk);
        pnl_start <= 1'b0;
        @(negedge clk);
        compare_value("pnl_running", 64'(pnl_running), 64'd1);
        cycles = 0;
        while (pnl_running) begin
            if (cycles == RUN_TIMEOUT) begin
                abort_run("the run did not reach a stop order in time");
            end
            @(negedge clk);
            cycles = cycles + 1;
        end
    endtask

    task automatic run_program(input int mode, input int n_orders);
        addr_t            start_addr;
        logic [`OP_W-1:0] op;
        logic [`OP_W-1:0] stop_op;
        instr_t           ins;
        word_t            w;
        int               i;
        for (i = 0; i < DATA_N; i++) begin
            w = random_word();
            if (i > 0 && $urandom_range(3, 0) == 0) begin
                w.mag = model_mem[addr_t'(DATA_BASE + i - 1)].mag;    // equal magnitudes
            end
            deposit(addr_t'(DATA_BASE + i), w);
        end

        start_addr = addr_t'(PROG_BASE + $urandom_range(240, 0));
        w.sign     = 1'b0;
        for (i = 0; i < n_orders; i++) begin
            case (mode)
                MODE_AND:    op = `OP_AND;
                MODE_OUTPUT: op = `OP_OUTPUT;
                MODE_MIXED:  op = `OP_W'($urandom_range(4, 1));
                default:     op = ($urandom_range(1, 0) == 1) ? `OP_SUB : `OP_ADD;
            endcase
            ins.op    = op;
            ins.addr1 = addr_t'(DATA_BASE + $urandom_range(DATA_N - 1, 0));
            ins.addr2 = addr_t'(DATA_BASE + $urandom_range(DATA_N - 1, 0));
            w.mag     = ins;
            deposit(start_addr + addr_t'(i), w);
        end

        stop_op   = (mode == MODE_UNDEF) ? `OP_W'($urandom_range(63, 5)) : `OP_STOP;
        ins.op    = stop_op;
        ins.addr1 = addr_t'($urandom);
        ins.addr2 = addr_t'($urandom);
        w.mag     = ins;
        deposit(start_addr + addr_t'(n_orders), w);
        // never executes since it follows the stop
        ins.op    = `OP_ADD;
        ins.addr1 = addr_t'(DATA_BASE);
        ins.addr2 = addr_t'(DATA_BASE + 1);
        w.mag     = ins;
        deposit(start_addr + addr_t'(n_orders + 1), w);

        exp_digits.delete();
        seen_digits.delete();
        model_run(start_addr);
        set_strt(start_addr);
        start_run();

        compare_value("pnl_strt_value", 64'(pnl_strt_value),
                      64'(start_addr + addr_t'(n_orders + 1)));
        compare_value("pnl_op_code", 64'(pnl_op_code), 64'(stop_op));
        compare_value("output digit count", 64'(seen_digits.size()), 64'(exp_digits.size()));
        for (i = 0; i < exp_digits.size(); i++) begin
            compare_value("dev_output_data", 64'(seen_digits[i]), 64'(exp_digits[i]));
        end
        for (i = 0; i < DATA_N; i++) begin
            read_word(addr_t'(DATA_BASE + i));
        end
    endtask

    initial begin
        addr_t addrs [8];
        int    i;
        void'($urandom(32'h2565ec74));
        rst_n               = 1'b0;
        pnl_do_arr_c        = 1'b0;
        pnl_arr_reg_c_value = '0;
        pnl_do_arr_strt     = 1'b0;
        pnl_arr_strt_value  = '0;
        pnl_do_arr_sel      = 1'b0;
        pnl_arr_sel_value   = '0;
        pnl_do_write        = 1'b0;
        pnl_do_read         = 1'b0;
        pnl_start           = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        compare_value("pnl_running", 64'(pnl_running), 64'd0);
        compare_value("dev_output_rdy", 64'(dev_output_rdy), 64'd0);
        compare_value("pnl_op_code", 64'(pnl_op_code), 64'd0);
        compare_value("pnl_strt_value", 64'(pnl_strt_value), 64'd0);
        compare_value("pnl_sel_value", 64'(pnl_sel_value), 64'd0);
        compare_value("pnl_reg_c_value", 64'(pnl_reg_c_value), 64'd0);

        // one random address in each eighth of memory
        for (i = 0; i < 8; i++) begin
            addrs[i] = addr_t'(i * 512 + $urandom_range(511, 0));
            deposit(addrs[i], random_word());
        end
        for (i = 0; i < 8; i++) begin
            read_word(addrs[i]);
        end

        repeat (3) run_program(MODE_ADDSUB, $urandom_range(8, 3));
        repeat (2) run_program(MODE_AND, $urandom_range(6, 2));
        repeat (2) run_program(MODE_OUTPUT, $urandom_range(4, 1));
        repeat (2) run_program(MODE_MIXED, $urandom_range(8, 3));
        repeat (2) run_program(MODE_UNDEF, $urandom_range(3, 1));

        $display("Verification passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/core_pkg.sv
hw/arith_unit.sv
hw/operator.sv
hw/pulse_unit.sv
hw/addr_regs.sv
hw/memory.sv
hw/io_unit.sv
hw/core_top.sv
dv/core_sva.sv
dv/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module core_tb -f flist.f \
    && ./obj_dir/Vcore_tb 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -qx "Verification passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
